/* compile.f */
+incdir+logic
logic/dma_pkg.sv
logic/dma_cmd_table.sv
logic/dma_channel.sv
logic/dma_src_port.sv
logic/dma_snk_port.sv
logic/dma_top.sv
tb/dma_chk.sv
tb/tb_dma.sv

/* tb/tb_dma.sv */
`timescale 1ns/1ns
`include "dma_params.svh"

module tb_dma;

  logic                 clk;
  logic                 rst;
  dma_pkg::dma_ctrl_t   ctrl;
  logic                 cmd_we;
  dma_pkg::cmd_idx_t    cmd_idx;
  dma_pkg::dma_cmd_t    cmd;
  dma_pkg::dma_status_t status;
  logic                 src_ready;
  dma_pkg::count_t      src_size;
  dma_pkg::data_t       src_data;
  dma_pkg::src_req_t    src_req;
  logic                 snk_ready;
  dma_pkg::count_t      snk_size;
  dma_pkg::snk_req_t    snk_req;

  dma_pkg::dma_cmd_t    prog [`DMA_CMD_COUNT];
  dma_pkg::addr_t       exp_addr [$];
  dma_pkg::addr_t       exp_src_addr [$];
  logic [1:0]           exp_dst_step [$];
  logic [1:0]           exp_src_step [$];
  logic                 cmd_first [$];
  logic [31:0]          lfsr;
  int                   total_words;
  int                   src_popped;
  int                   snk_words;
  int                   cycles;
  logic                 snk_first;
  logic                 src_first;

  dma_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_ctrl      (ctrl),
    .i_cmd_we    (cmd_we),
    .i_cmd_idx   (cmd_idx),
    .i_cmd       (cmd),
    .o_status    (status),
    .i_src_ready (src_ready),
    .i_src_size  (src_size),
    .i_src_data  (src_data),
    .o_src       (src_req),
    .i_snk_ready (snk_ready),
    .i_snk_size  (snk_size),
    .o_snk       (snk_req)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Source FIFO pops a plain counter sequence
  function automatic dma_pkg::data_t word_at(int n);
    return dma_pkg::data_t'(32'hd000_0000 + n);
  endfunction

  function automatic dma_pkg::dma_cmd_t make_cmd(dma_pkg::addr_t src, dma_pkg::addr_t dst,
                                                 int count, logic [6:0] flags, int next);
    dma_pkg::dma_cmd_t c;
    c.src_addr = src;
    c.dst_addr = dst;
    c.count    = dma_pkg::count_t'(count);
    c.flags    = dma_pkg::cmd_flags_t'(flags);
    c.next     = dma_pkg::cmd_idx_t'(next);
    return c;
  endfunction

  // Walk the chain from entry 0 and list the addresses and steps of every word
  function automatic void compute_expected();
    dma_pkg::cmd_idx_t idx;
    dma_pkg::addr_t    cur;
    dma_pkg::addr_t    src_cur;
    logic              halted;
    idx         = '0;
    cur         = prog[0].dst_addr;
    src_cur     = prog[0].src_addr;
    halted      = 1'b0;
    total_words = 0;
    while (!halted) begin
      if (prog[idx].flags.dst_reload) begin
        cur = prog[idx].dst_addr;
      end
      if (prog[idx].flags.src_reload) begin
        src_cur = prog[idx].src_addr;
      end
      for (int k = 0; k < int'(prog[idx].count); k++) begin
        exp_addr.push_back(cur);
        exp_src_addr.push_back(src_cur);
        exp_dst_step.push_back({prog[idx].flags.dst_inc, prog[idx].flags.dst_dec});
        exp_src_step.push_back({prog[idx].flags.src_inc, prog[idx].flags.src_dec});
        cmd_first.push_back(k == 0);
        if (prog[idx].flags.dst_inc) begin
          cur = cur + `DMA_WORD_BYTES;
        end else if (prog[idx].flags.dst_dec) begin
          cur = cur - `DMA_WORD_BYTES;
        end
        if (prog[idx].flags.src_inc) begin
          src_cur = src_cur + `DMA_WORD_BYTES;
        end else if (prog[idx].flags.src_dec) begin
          src_cur = src_cur - `DMA_WORD_BYTES;
        end
      end
      total_words += int'(prog[idx].count);
      halted = prog[idx].flags.halt;
      idx    = prog[idx].next;
    end
  endfunction

  task automatic report_error(string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  // Run limit scales with the words in the chain
  always @(posedge clk) begin
    cycles++;
    if (cycles > 20 * total_words) begin
      $display("Timeout: the DMA chain did not complete within %0d cycles", cycles - 1);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout");
    end
  end

  // Source FIFO inputs change 1 ns after each rising edge
  always @(posedge clk) begin
    #1;
    src_data  = word_at(src_popped);
    src_ready = take_bits(1) != 0;
    src_size  = dma_pkg::count_t'(take_bits(3) + 1);
  end

  // Sink FIFO model sampled mid-cycle
  always @(negedge clk) begin
    assert (i_dut.u_chk.err_count == 0)
      else report_error("a bound assertion in dma_chk failed");
    if (!rst) begin
      if (snk_req.strobe) begin
        assert (snk_words < total_words)
          else report_error("sink received more words than the chain holds");
        assert (snk_req.data == word_at(snk_words))
          else report_error($sformatf("sink word %0d is %h, expected %h",
                                      snk_words, snk_req.data, word_at(snk_words)));
        if (snk_first) begin
          assert (snk_req.address == exp_addr[snk_words])
            else report_error($sformatf("sink block at word %0d has address %h, expected %h",
                                        snk_words, snk_req.address, exp_addr[snk_words]));
          assert ({snk_req.addr_inc, snk_req.addr_dec} == exp_dst_step[snk_words])
            else report_error($sformatf("sink block at word %0d has step %b, expected %b",
                                        snk_words, {snk_req.addr_inc, snk_req.addr_dec},
                                        exp_dst_step[snk_words]));
        end
        snk_words++;
      end
      if (src_req.strobe) begin
        // A block opening at a command boundary may carry the previous command
        if (src_first && src_popped < total_words && !cmd_first[src_popped]) begin
          assert (src_req.address == exp_src_addr[src_popped])
            else report_error($sformatf("source block at word %0d has address %h, expected %h",
                                        src_popped, src_req.address,
                                        exp_src_addr[src_popped]));
          assert ({src_req.addr_inc, src_req.addr_dec} == exp_src_step[src_popped])
            else report_error($sformatf("source block at word %0d has step %b, expected %b",
                                        src_popped, {src_req.addr_inc, src_req.addr_dec},
                                        exp_src_step[src_popped]));
        end
        src_popped++;
      end
      if (!snk_req.activate) begin
        snk_first = 1'b1;
      end else if (snk_req.strobe) begin
        snk_first = 1'b0;
      end
      if (!src_req.activate) begin
        src_first = 1'b1;
      end else if (src_req.strobe) begin
        src_first = 1'b0;
      end
      assert (!status.finished || snk_words == total_words)
        else report_error("finished rose before the halt command completed");
    end
  end

  initial begin
    lfsr       = 32'hc388;
    rst        = 1'b1;
    ctrl       = '0;
    cmd_we     = 1'b0;
    cmd_idx    = '0;
    cmd        = '0;
    src_ready  = 1'b0;
    src_size   = '0;
    src_data   = '0;
    snk_ready  = 1'b0;
    snk_size   = '0;
    src_popped = 0;
    snk_words  = 0;
    cycles     = 0;
    snk_first  = 1'b1;
    src_first  = 1'b1;
    for (int k = 0; k < `DMA_CMD_COUNT; k++) begin
      prog[k] = '0;
    end
    // Flag bits are src inc dec reload then dst inc dec reload then halt
    prog[0] = make_cmd(32'h1000, 32'h8000, 7, 7'b100_100_0, 2);
    prog[1] = make_cmd(32'h4000, 32'hc000, 3, 7'b100_101_1, 0);
    prog[2] = make_cmd(32'h2000, 32'h9000, 9, 7'b011_010_0, 5);
    prog[5] = make_cmd(32'h3000, 32'ha000, 6, 7'b100_001_1, 0);
    compute_expected();
    repeat (4) @(posedge clk);
    #1;
    rst       = 1'b0;
    snk_ready = 1'b1;
    snk_size  = 24'd5;
    for (int k = 0; k < `DMA_CMD_COUNT; k++) begin
      cmd_we  = 1'b1;
      cmd_idx = dma_pkg::cmd_idx_t'(k);
      cmd     = prog[k];
      @(posedge clk);
      #1;
    end
    cmd_we = 1'b0;
    ctrl   = '{enable: 1'b1, start_idx: 3'd0};
    @(posedge clk);
    @(negedge clk);
    assert (status.busy)
      else report_error("busy did not rise one cycle after enable");
    while (!status.finished) begin
      @(negedge clk);
    end
    assert (snk_words == total_words && src_popped == total_words)
      else report_error($sformatf("%0d words at the sink, %0d from the source, expected %0d",
                                  snk_words, src_popped, total_words));
    @(posedge clk);
    #1;
    ctrl.enable = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (!status.busy && !status.finished)
      else report_error("busy or finished still set 2 cycles after enable fell");
    if (i_dut.u_chk.err_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "Bound assertions failed");
    end
  end

endmodule

/* tb/dma_chk.sv */
`timescale 1ns/1ns

module dma_chk (
  input logic                 clk,
  input logic                 rst,
  input dma_pkg::src_req_t    i_src,
  input dma_pkg::snk_req_t    i_snk,
  input dma_pkg::count_t      i_src_size,
  input dma_pkg::count_t      i_snk_size,
  input logic                 i_close,
  input dma_pkg::dma_status_t i_status
);

  int unsigned     err_count;
  dma_pkg::count_t src_cnt;
  dma_pkg::count_t snk_cnt;
  dma_pkg::count_t src_size_q;
  dma_pkg::count_t snk_size_q;

  initial err_count = 0;

  // Strobes in the open block and the size granted when it opened
  always_ff @(posedge clk) begin
    if (rst || !i_src.activate) begin
      src_cnt    <= '0;
      src_size_q <= i_src_size;
    end else if (i_src.strobe) begin
      src_cnt <= src_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !i_snk.activate) begin
      snk_cnt    <= '0;
      snk_size_q <= i_snk_size;
    end else if (i_snk.strobe) begin
      snk_cnt <= snk_cnt + 1'b1;
    end
  end

  a_strobe_in_block: assert property (@(posedge clk) disable iff (rst)
    (!i_src.strobe || i_src.activate) && (!i_snk.strobe || i_snk.activate))
    else begin
      $error("strobe outside an active block");
      err_count++;
    end

  a_within_credit: assert property (@(posedge clk) disable iff (rst)
    (!i_src.strobe || src_cnt < src_size_q) && (!i_snk.strobe || snk_cnt < snk_size_q))
    else begin
      $error("more strobes than the granted block size");
      err_count++;
    end

  a_strobes_paired: assert property (@(posedge clk) disable iff (rst)
    i_src.strobe == i_snk.strobe)
    else begin
      $error("source and sink strobes differ");
      err_count++;
    end

  a_src_addr_stable: assert property (@(posedge clk) disable iff (rst)
    i_src.activate |=> (!i_src.activate || $stable(i_src.address)))
    else begin
      $error("source address changed inside a block");
      err_count++;
    end

  a_snk_addr_stable: assert property (@(posedge clk) disable iff (rst)
    i_snk.activate |=> (!i_snk.activate || $stable(i_snk.address)))
    else begin
      $error("sink address changed inside a block");
      err_count++;
    end

  // Sink block is released at every command end
  a_snk_close: assert property (@(posedge clk) disable iff (rst)
    i_close |=> !i_snk.activate)
    else begin
      $error("sink block still open after command end");
      err_count++;
    end

  a_reset_idle: assert property (@(posedge clk)
    rst |=> !i_src.activate && !i_snk.activate && !i_status.busy && !i_status.finished)
    else begin
      $error("activate or status set after reset");
      err_count++;
    end

endmodule

bind dma_top dma_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .i_src      (o_src),
  .i_snk      (o_snk),
  .i_src_size (i_src_size),
  .i_snk_size (i_snk_size),
  .i_close    (close_snk),
  .i_status   (o_status)
);

/* logic/dma_top.sv */
`timescale 1ns/1ns

module dma_top (
  input  logic                 clk,
  input  logic                 rst,
  input  dma_pkg::dma_ctrl_t   i_ctrl,
  input  logic                 i_cmd_we,
  input  dma_pkg::cmd_idx_t    i_cmd_idx,
  input  dma_pkg::dma_cmd_t    i_cmd,
  output dma_pkg::dma_status_t o_status,
  input  logic                 i_src_ready,
  input  dma_pkg::count_t      i_src_size,
  input  dma_pkg::data_t       i_src_data,
  output dma_pkg::src_req_t    o_src,
  input  logic                 i_snk_ready,
  input  dma_pkg::count_t      i_snk_size,
  output dma_pkg::snk_req_t    o_snk
);

  dma_pkg::cmd_idx_t   cur_idx;
  dma_pkg::dma_cmd_t   cur_cmd;
  dma_pkg::addr_t      src_addr;
  dma_pkg::addr_t      dst_addr;
  dma_pkg::cmd_flags_t step;
  logic                src_credit;
  logic                snk_credit;
  logic                en;
  logic                xfer;
  logic                close_snk;

  dma_cmd_table u_cmd_table (
    .clk    (clk),
    .rst    (rst),
    .i_we   (i_cmd_we),
    .i_widx (i_cmd_idx),
    .i_wcmd (i_cmd),
    .i_ridx (cur_idx),
    .o_rcmd (cur_cmd)
  );

  dma_channel u_channel (
    .clk          (clk),
    .rst          (rst),
    .i_ctrl       (i_ctrl),
    .i_cmd        (cur_cmd),
    .o_cmd_idx    (cur_idx),
    .i_src_credit (src_credit),
    .i_snk_credit (snk_credit),
    .o_en         (en),
    .o_xfer       (xfer),
    .o_close_snk  (close_snk),
    .o_src_addr   (src_addr),
    .o_dst_addr   (dst_addr),
    .o_src_step   (step),
    .o_status     (o_status)
  );

  dma_src_port u_src_port (
    .clk      (clk),
    .rst      (rst),
    .i_en     (en),
    .i_xfer   (xfer),
    .i_addr   (src_addr),
    .i_step   (step),
    .i_ready  (i_src_ready),
    .i_size   (i_src_size),
    .o_credit (src_credit),
    .o_req    (o_src)
  );

  dma_snk_port u_snk_port (
    .clk      (clk),
    .rst      (rst),
    .i_en     (en),
    .i_xfer   (xfer),
    .i_close  (close_snk),
    .i_addr   (dst_addr),
    .i_step   (step),
    .i_data   (i_src_data),
    .i_ready  (i_snk_ready),
    .i_size   (i_snk_size),
    .o_credit (snk_credit),
    .o_req    (o_snk)
  );

endmodule

/* logic/dma_snk_port.sv */
`timescale 1ns/1ns

module dma_snk_port (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_en,
  input  logic                i_xfer,
  input  logic                i_close,
  input  dma_pkg::addr_t      i_addr,
  input  dma_pkg::cmd_flags_t i_step,
  input  dma_pkg::data_t      i_data,
  input  logic                i_ready,
  input  dma_pkg::count_t     i_size,
  output logic                o_credit,
  output dma_pkg::snk_req_t   o_req
);

  logic            open_q;
  logic            opening;
  dma_pkg::count_t cnt;
  dma_pkg::count_t cnt_nxt;
  dma_pkg::count_t size_q;
  dma_pkg::addr_t  addr_q;
  logic            inc_q;
  logic            dec_q;

  assign o_credit = open_q && (cnt < size_q);
  assign cnt_nxt  = cnt + dma_pkg::count_t'(i_xfer && o_credit);
  // No new block while a command is closing
  assign opening  = i_en && !i_close && !open_q && i_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      open_q <= 1'b0;
      cnt    <= '0;
    end else if (!i_en || i_close) begin
      // Partial block released at command end
      open_q <= 1'b0;
    end else if (!open_q) begin
      if (opening) begin
        open_q <= 1'b1;
        cnt    <= '0;
      end
    end else begin
      cnt <= cnt_nxt;
      if (cnt_nxt >= size_q) begin
        open_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (opening) begin
      size_q <= i_size;
      addr_q <= i_addr;
      inc_q  <= i_step.dst_inc;
      dec_q  <= i_step.dst_dec;
    end
  end

  // Head word of the source goes out with the strobe
  assign o_req = '{activate: open_q, strobe: i_xfer && o_credit, data: i_data,
                   address: addr_q, addr_inc: inc_q, addr_dec: dec_q};

endmodule

/* logic/dma_src_port.sv */
`timescale 1ns/1ns

module dma_src_port (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_en,
  input  logic                i_xfer,
  input  dma_pkg::addr_t      i_addr,
  input  dma_pkg::cmd_flags_t i_step,
  input  logic                i_ready,
  input  dma_pkg::count_t     i_size,
  output logic                o_credit,
  output dma_pkg::src_req_t   o_req
);

  logic            open_q;
  dma_pkg::count_t cnt;
  dma_pkg::count_t cnt_nxt;
  dma_pkg::count_t size_q;
  dma_pkg::addr_t  addr_q;
  logic            inc_q;
  logic            dec_q;

  assign o_credit = open_q && (cnt < size_q);
  assign cnt_nxt  = cnt + dma_pkg::count_t'(i_xfer && o_credit);

  always_ff @(posedge clk) begin
    if (rst) begin
      open_q <= 1'b0;
      cnt    <= '0;
    end else if (!i_en) begin
      open_q <= 1'b0;
    end else if (!open_q) begin
      if (i_ready) begin
        open_q <= 1'b1;
        cnt    <= '0;
      end
    end else begin
      cnt <= cnt_nxt;
      // Last credit spent
      if (cnt_nxt >= size_q) begin
        open_q <= 1'b0;
      end
    end
  end

  // Block parameters latched at activation
  always_ff @(posedge clk) begin
    if (i_en && !open_q && i_ready) begin
      size_q <= i_size;
      addr_q <= i_addr;
      inc_q  <= i_step.src_inc;
      dec_q  <= i_step.src_dec;
    end
  end

  assign o_req = '{activate: open_q, strobe: i_xfer && o_credit, address: addr_q,
                   addr_inc: inc_q, addr_dec: dec_q};

endmodule

/* logic/dma_channel.sv */
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_channel (
  input  logic                 clk,
  input  logic                 rst,
  input  dma_pkg::dma_ctrl_t   i_ctrl,
  input  dma_pkg::dma_cmd_t    i_cmd,
  output dma_pkg::cmd_idx_t    o_cmd_idx,
  input  logic                 i_src_credit,
  input  logic                 i_snk_credit,
  output logic                 o_en,
  output logic                 o_xfer,
  output logic                 o_close_snk,
  output dma_pkg::addr_t       o_src_addr,
  output dma_pkg::addr_t       o_dst_addr,
  output dma_pkg::cmd_flags_t  o_src_step,
  output dma_pkg::dma_status_t o_status
);

  dma_pkg::chan_state_e state;
  dma_pkg::cmd_idx_t    cur_idx;
  dma_pkg::count_t      moved;
  dma_pkg::count_t      moved_nxt;
  dma_pkg::addr_t       src_addr_q;
  dma_pkg::addr_t       dst_addr_q;
  logic                 busy_q;
  logic                 finished_q;

  function automatic dma_pkg::addr_t step_addr(dma_pkg::addr_t a, logic inc, logic dec);
    dma_pkg::addr_t r;
    r = a;
    if (inc) begin
      r = a + dma_pkg::addr_t'(`DMA_WORD_BYTES);
    end else if (dec) begin
      r = a - dma_pkg::addr_t'(`DMA_WORD_BYTES);
    end
    return r;
  endfunction

  // Ports run from command setup through command end
  assign o_en = i_ctrl.enable &&
                (state == dma_pkg::SETUP_COMMAND || state == dma_pkg::ACTIVE ||
                 state == dma_pkg::END_COMMAND);

  assign o_xfer = (state == dma_pkg::ACTIVE) && i_src_credit && i_snk_credit &&
                  (moved != i_cmd.count);

  assign o_close_snk = (state == dma_pkg::END_COMMAND);
  assign moved_nxt   = moved + dma_pkg::count_t'(o_xfer);

  // During setup a port that opens must already see the reloaded address
  assign o_src_addr = (state == dma_pkg::SETUP_COMMAND && i_cmd.flags.src_reload) ?
                      i_cmd.src_addr : src_addr_q;
  assign o_dst_addr = (state == dma_pkg::SETUP_COMMAND && i_cmd.flags.dst_reload) ?
                      i_cmd.dst_addr : dst_addr_q;

  assign o_src_step = i_cmd.flags;
  assign o_cmd_idx  = cur_idx;
  assign o_status   = '{busy: busy_q, finished: finished_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dma_pkg::IDLE;
      cur_idx    <= '0;
      moved      <= '0;
      busy_q     <= 1'b0;
      finished_q <= 1'b0;
    end else if (!i_ctrl.enable && state != dma_pkg::IDLE) begin
      // Enable dropped, ports release their blocks
      state      <= dma_pkg::IDLE;
      busy_q     <= 1'b0;
      finished_q <= 1'b0;
    end else begin
      case (state)
        dma_pkg::IDLE: begin
          if (i_ctrl.enable) begin
            state   <= dma_pkg::SETUP_CHANNEL;
            busy_q  <= 1'b1;
            cur_idx <= i_ctrl.start_idx;
          end
        end
        dma_pkg::SETUP_CHANNEL: begin
          state <= dma_pkg::SETUP_COMMAND;
        end
        dma_pkg::SETUP_COMMAND: begin
          moved <= '0;
          state <= dma_pkg::ACTIVE;
        end
        dma_pkg::ACTIVE: begin
          moved <= moved_nxt;
          if (moved_nxt == i_cmd.count) begin
            state <= dma_pkg::END_COMMAND;
          end
        end
        dma_pkg::END_COMMAND: begin
          if (i_cmd.flags.halt) begin
            state      <= dma_pkg::FINISHED;
            finished_q <= 1'b1;
          end else begin
            cur_idx <= i_cmd.next;
            state   <= dma_pkg::SETUP_COMMAND;
          end
        end
        // FINISHED waits here for enable to fall
        default: ;
      endcase
    end
  end

  // Address engine
  always_ff @(posedge clk) begin
    case (state)
      dma_pkg::SETUP_CHANNEL: begin
        src_addr_q <= i_cmd.src_addr;
        dst_addr_q <= i_cmd.dst_addr;
      end
      dma_pkg::SETUP_COMMAND: begin
        src_addr_q <= o_src_addr;
        dst_addr_q <= o_dst_addr;
      end
      dma_pkg::ACTIVE: begin
        if (o_xfer) begin
          src_addr_q <= step_addr(src_addr_q, i_cmd.flags.src_inc, i_cmd.flags.src_dec);
          dst_addr_q <= step_addr(dst_addr_q, i_cmd.flags.dst_inc, i_cmd.flags.dst_dec);
        end
      end
      default: ;
    endcase
  end

endmodule

/* logic/dma_cmd_table.sv */
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_cmd_table (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_we,
  input  dma_pkg::cmd_idx_t   i_widx,
  input  dma_pkg::dma_cmd_t   i_wcmd,
  input  dma_pkg::cmd_idx_t   i_ridx,
  output dma_pkg::dma_cmd_t   o_rcmd
);

  dma_pkg::dma_cmd_t cmd_mem [`DMA_CMD_COUNT];

  // Host writes land at the next edge
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DMA_CMD_COUNT; i++) begin
        cmd_mem[i] <= '0;
      end
    end else if (i_we) begin
      cmd_mem[i_widx] <= i_wcmd;
    end
  end

  // Channel sees its current entry without a cycle of delay
  assign o_rcmd = cmd_mem[i_ridx];

endmodule

/* logic/dma_pkg.sv */
`include "dma_params.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0]    addr_t;
  typedef logic [`DMA_DATA_W-1:0]    data_t;
  typedef logic [`DMA_COUNT_W-1:0]   count_t;
  typedef logic [`DMA_CMD_IDX_W-1:0] cmd_idx_t;

  typedef struct packed {
    logic src_inc;
    logic src_dec;
    logic src_reload;
    logic dst_inc;
    logic dst_dec;
    logic dst_reload;
    logic halt;
  } cmd_flags_t;

  typedef struct packed {
    addr_t      src_addr;
    addr_t      dst_addr;
    count_t     count;
    cmd_flags_t flags;
    cmd_idx_t   next;
  } dma_cmd_t;

  typedef struct packed {
    logic     enable;
    cmd_idx_t start_idx;
  } dma_ctrl_t;

  typedef struct packed {
    logic busy;
    logic finished;
  } dma_status_t;

  // Toward the source FIFO
  typedef struct packed {
    logic  activate;
    logic  strobe;
    addr_t address;
    logic  addr_inc;
    logic  addr_dec;
  } src_req_t;

  // Toward the sink FIFO
  typedef struct packed {
    logic  activate;
    logic  strobe;
    data_t data;
    addr_t address;
    logic  addr_inc;
    logic  addr_dec;
  } snk_req_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP_CHANNEL,
    SETUP_COMMAND,
    ACTIVE,
    END_COMMAND,
    FINISHED
  } chan_state_e;

endpackage

/* logic/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Command table depth and index width
`define DMA_CMD_COUNT   8
`define DMA_CMD_IDX_W   3

// Datapath widths
`define DMA_DATA_W      32
`define DMA_ADDR_W      32

// Word counts and FIFO block sizes
`define DMA_COUNT_W     24

// Byte step per word moved
`define DMA_WORD_BYTES  4

`endif
